// ==== kernelPkg.sv ====
`default_nettype none

package kernelPkg;

	localparam int PIXEL_W = 8;
	localparam int COEF_W = 8;
	localparam int KERNEL_DIM = 3;

	// Pixel gets a sign bit before the multiply
	localparam int PRODUCT_W = PIXEL_W + COEF_W + 1;
	// Headroom for nine products
	localparam int SUM_W = PRODUCT_W + 4;

	typedef logic [PIXEL_W-1:0] pixel_t;
	typedef logic signed [COEF_W-1:0] coef_t;
	typedef logic signed [PRODUCT_W-1:0] product_t;
	typedef logic signed [SUM_W-1:0] sum_t;

	// Row-major with element 0 at the top-left
	typedef coef_t [KERNEL_DIM*KERNEL_DIM-1:0] kernel_t;

	// Indexed [row][column], row 0 is the top row of the window
	typedef pixel_t [KERNEL_DIM-1:0][KERNEL_DIM-1:0] window_t;

	localparam kernel_t SHARPEN_KERNEL = {
		-8'sd1, -8'sd1, -8'sd1,
		-8'sd1,  8'sd9, -8'sd1,
		-8'sd1, -8'sd1, -8'sd1
	};

endpackage

`default_nettype wire

// ==== frameBusPkg.sv ====
`default_nettype none

package frameBusPkg;

	localparam int ADDR_W = 32;
	localparam int ROW_PIXELS = 8;
	localparam int LANES = 4;

	typedef logic [ADDR_W-1:0] addr_t;

	// Pixel 0 sits in the low byte
	typedef kernelPkg::pixel_t [ROW_PIXELS-1:0] rowWord_t;

	// Lane 0 sits in the low byte
	typedef kernelPkg::pixel_t [LANES-1:0] outWord_t;

	typedef struct packed {
		logic fire;
		logic last;
	} fireTag_t;

endpackage

`default_nettype wire

// ==== kernelLane.sv ====
`timescale 1ns/1ps
`default_nettype none

module kernelLane #(
	parameter kernelPkg::kernel_t KERNEL = kernelPkg::SHARPEN_KERNEL
) (
	input wire logic clk,
	input wire logic reset,
	input wire kernelPkg::window_t i_window,
	output kernelPkg::pixel_t o_pixel
);
	import kernelPkg::*;

	localparam sum_t PIXEL_MAX = sum_t'((1 << PIXEL_W) - 1);

	product_t products [KERNEL_DIM][KERNEL_DIM];
	sum_t rowSums [KERNEL_DIM];
	sum_t total;

	// Stage 1
	// Nine signed products, pixel zero-extended first
	always_ff @(posedge clk) begin
		for (int i = 0; i < KERNEL_DIM; i++) begin
			for (int j = 0; j < KERNEL_DIM; j++) begin
				products[i][j] <= product_t'($signed({1'b0, i_window[i][j]}))
					* product_t'(KERNEL[i*KERNEL_DIM+j]);
			end
		end
	end

	// Stage 2
	// One sum per kernel row
	always_ff @(posedge clk) begin
		for (int i = 0; i < KERNEL_DIM; i++) begin
			rowSums[i] <= sum_t'(products[i][0])
				+ sum_t'(products[i][1])
				+ sum_t'(products[i][2]);
		end
	end

	// Stage 3
	always_ff @(posedge clk) begin
		total <= rowSums[0] + rowSums[1] + rowSums[2];
	end

	// Stage 4
	// Saturate into the pixel range
	always_ff @(posedge clk) begin
		if (reset) begin
			o_pixel <= '0;
		end else if (total > PIXEL_MAX) begin
			o_pixel <= '1;
		end else if (total < 0) begin
			o_pixel <= '0;
		end else begin
			o_pixel <= total[PIXEL_W-1:0];
		end
	end

endmodule

`default_nettype wire

// ==== filterArray.sv ====
`timescale 1ns/1ps
`default_nettype none

module filterArray #(
	parameter kernelPkg::kernel_t KERNEL = kernelPkg::SHARPEN_KERNEL
) (
	input wire logic clk,
	input wire logic reset,
	input wire frameBusPkg::rowWord_t i_data,
	input wire logic i_rowShift,
	input wire frameBusPkg::fireTag_t i_fireTag,
	output frameBusPkg::outWord_t o_data,
	output logic o_valid,
	output logic o_done
);
	import kernelPkg::*;
	import frameBusPkg::*;

	// Matches the kernelLane pipeline depth
	localparam int TAG_DEPTH = 4;

	// Oldest row at index 0
	rowWord_t rowStore [KERNEL_DIM];
	window_t windows [LANES];
	pixel_t lanePixels [LANES];
	fireTag_t tagLine [TAG_DEPTH];

	// Row store shifts up and takes the new row at the bottom
	always_ff @(posedge clk) begin
		if (i_rowShift) begin
			for (int i = 0; i < KERNEL_DIM - 1; i++) begin
				rowStore[i] <= rowStore[i+1];
			end
			rowStore[KERNEL_DIM-1] <= i_data;
		end
	end

	// Lane k sees columns k to k+2 of the stored rows
	always_comb begin
		for (int k = 0; k < LANES; k++) begin
			for (int i = 0; i < KERNEL_DIM; i++) begin
				for (int j = 0; j < KERNEL_DIM; j++) begin
					windows[k][i][j] = rowStore[i][k+j];
				end
			end
		end
	end

	for (genvar k = 0; k < LANES; k++) begin : gLane
		kernelLane #(
			.KERNEL(KERNEL)
		) u_lane (
			.clk(clk),
			.reset(reset),
			.i_window(windows[k]),
			.o_pixel(lanePixels[k])
		);
	end

	// Fire and last ride alongside the lane pipeline
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < TAG_DEPTH; i++) begin
				tagLine[i] <= '0;
			end
		end else begin
			tagLine[0] <= i_fireTag;
			for (int i = 1; i < TAG_DEPTH; i++) begin
				tagLine[i] <= tagLine[i-1];
			end
		end
	end

	assign o_valid = tagLine[TAG_DEPTH-1].fire;
	assign o_done = tagLine[TAG_DEPTH-1].last;

	always_comb begin
		for (int k = 0; k < LANES; k++) begin
			o_data[k] = lanePixels[k];
		end
	end

endmodule

`default_nettype wire

// ==== stripeSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module stripeSequencer #(
	parameter int IMG_WIDTH = 8,
	parameter int IMG_HEIGHT = 4
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic i_valid,
	output logic o_req,
	output frameBusPkg::addr_t o_rdAddress,
	output logic o_rowShift,
	output frameBusPkg::fireTag_t o_fireTag
);
	import frameBusPkg::*;

	// Padded frame geometry
	localparam int STRIDE = IMG_WIDTH + 2;
	localparam int ROWS = IMG_HEIGHT + 2;
	localparam int STRIPES = IMG_WIDTH / LANES;

	localparam int ROW_W = $clog2(ROWS + 1);
	localparam int STRIPE_W = $clog2(STRIPES + 1);

	// Third padded row is the first to complete a window
	localparam int FIRST_FIRE_ROW = 2;

	typedef enum logic [1:0] {
		stateRequest,
		stateWait,
		stateFinished
	} seqState_t;

	seqState_t state;
	logic [ROW_W-1:0] rowCnt;
	logic [STRIPE_W-1:0] stripeCnt;
	addr_t stripeBase;
	logic lastRow;
	logic lastStripe;
	logic rowShift;

	assign lastRow = (rowCnt == ROW_W'(ROWS - 1));
	assign lastStripe = (stripeCnt == STRIPE_W'(STRIPES - 1));

	// Row data is only good in the cycle it arrives
	assign rowShift = (state == stateWait) && i_valid;
	assign o_rowShift = rowShift;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stateRequest;
			o_req <= 1'b0;
			o_rdAddress <= '0;
			o_fireTag <= '0;
			rowCnt <= '0;
			stripeCnt <= '0;
			stripeBase <= '0;
		end else begin
			o_req <= 1'b0;

			// Fire one cycle after the shift that fills a window
			o_fireTag.fire <= rowShift && (rowCnt >= ROW_W'(FIRST_FIRE_ROW));
			o_fireTag.last <= rowShift && lastRow && lastStripe;

			case (state)
				stateRequest: begin
					o_req <= 1'b1;
					state <= stateWait;
				end
				stateWait: begin
					if (i_valid) begin
						if (lastRow && lastStripe) begin
							state <= stateFinished;
						end else if (lastRow) begin
							// Back to the top row, one stripe to the right
							rowCnt <= '0;
							stripeCnt <= stripeCnt + 1'b1;
							stripeBase <= stripeBase + addr_t'(LANES);
							o_rdAddress <= stripeBase + addr_t'(LANES);
							o_req <= 1'b1;
						end else begin
							rowCnt <= rowCnt + 1'b1;
							o_rdAddress <= o_rdAddress + addr_t'(STRIDE);
							o_req <= 1'b1;
						end
					end
				end
				stateFinished: begin
					// Frame complete, idle until reset
					state <= stateFinished;
				end
				default: begin
					state <= stateRequest;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== convEngine.sv ====
`timescale 1ns/1ps
`default_nettype none

module convEngine #(
	parameter int IMG_WIDTH = 8,
	parameter int IMG_HEIGHT = 4,
	parameter kernelPkg::kernel_t KERNEL = kernelPkg::SHARPEN_KERNEL
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic i_valid,
	input wire frameBusPkg::rowWord_t i_data,
	output logic o_req,
	output frameBusPkg::addr_t o_rdAddress,
	output frameBusPkg::outWord_t o_data,
	output logic o_valid,
	output logic o_done
);
	import frameBusPkg::*;

	// Strobe and tag between sequencer and filter
	logic rowShift;
	fireTag_t fireTag;

	// Memory side
	stripeSequencer #(
		.IMG_WIDTH(IMG_WIDTH),
		.IMG_HEIGHT(IMG_HEIGHT)
	) u_sequencer (
		.clk(clk),
		.reset(reset),
		.i_valid(i_valid),
		.o_req(o_req),
		.o_rdAddress(o_rdAddress),
		.o_rowShift(rowShift),
		.o_fireTag(fireTag)
	);

	// Row data goes straight in and is captured on the strobe
	filterArray #(
		.KERNEL(KERNEL)
	) u_filter (
		.clk(clk),
		.reset(reset),
		.i_data(i_data),
		.i_rowShift(rowShift),
		.i_fireTag(fireTag),
		.o_data(o_data),
		.o_valid(o_valid),
		.o_done(o_done)
	);

endmodule

`default_nettype wire

// ==== tb_convEngine.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_convEngine;
	import kernelPkg::*;
	import frameBusPkg::*;

	localparam int PAD_W = 10;
	localparam int PAD_H = 6;
	localparam int FRAME_PIXELS = PAD_W * PAD_H;
	localparam int WORDS = 8;
	localparam int MAX_TESTS = 8;
	localparam int MEM_SIZE = 80;
	localparam int RESET_CYCLES = 10;
	localparam int FIRST_FIRE_ROW = 2;
	localparam int FIRE_LATENCY = 5;
	localparam int QUIET_CYCLES = 20;
	localparam int CYCLES_PER_TEST = 200;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic i_valid = 1'b0;
	rowWord_t i_data = '0;
	logic o_req;
	addr_t o_rdAddress;
	outWord_t o_data;
	logic o_valid;
	logic o_done;

	string testNames [MAX_TESTS];
	int abortAt [MAX_TESTS];
	pixel_t frames [MAX_TESTS][FRAME_PIXELS];
	outWord_t expected [MAX_TESTS][WORDS];
	int numTests = 0;
	int errorCount = 0;

	// Memory model
	pixel_t mem [MEM_SIZE];
	int checkFrame = -1;
	logic [31:0] lcgState = 32'hd259;
	logic resetAtEdge;
	logic pending = 1'b0;
	int countdown = 0;
	int reqCount = 0;
	addr_t reqAddress;

	// Monitor
	int cycleCount = 0;
	logic resetPrev = 1'b1;
	int rowsSeen = 0;
	int wordsSeen = 0;
	logic doneSeen = 1'b0;
	int fireCycles [$];

	convEngine u_dut (
		.clk(clk),
		.reset(reset),
		.i_valid(i_valid),
		.i_data(i_data),
		.o_req(o_req),
		.o_rdAddress(o_rdAddress),
		.o_data(o_data),
		.o_valid(o_valid),
		.o_done(o_done)
	);

	always begin
		#4;
		clk = ~clk;
	end

	function automatic logic [31:0] nextRandom(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic rowWord_t fetchRow(input addr_t address);
		rowWord_t row;
		for (int p = 0; p < ROW_PIXELS; p++) begin
			row[p] = (int'(address) + p < MEM_SIZE) ? mem[int'(address) + p] : '0;
		end
		return row;
	endfunction

	// Padded row r of stripe s starts at r times the stride plus 4 times s
	function automatic addr_t expectedAddress(input int reqIdx);
		return addr_t'((reqIdx % PAD_H) * PAD_W + LANES * (reqIdx / PAD_H));
	endfunction

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] want,
			input string what);
		if (actual !== want) begin
			$display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, actual, want);
			errorCount++;
		end
	endtask

	// Frame at the bottom, address-derived filler above it
	task automatic loadFrame(input int idx);
		for (int a = 0; a < MEM_SIZE; a++) begin
			if (idx >= 0 && a < FRAME_PIXELS)
				mem[a] = frames[idx][a];
			else
				mem[a] = pixel_t'((a * 37) ^ (a >> 3));
		end
	endtask

	task automatic loadTests();
		int fd;
		int got;
		int rowIdx;
		int wordIdx;
		int abort;
		int word;
		int px [PAD_W];
		string line;
		string tag;
		string name;
		rowIdx = PAD_H;
		wordIdx = WORDS;
		fd = $fopen("convEngine_testdata.txt", "r");
		if (fd == 0)
			return;
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			if (line.substr(0, 3) == "test" && numTests < MAX_TESTS) begin
				got = $sscanf(line, "%s %s %d", tag, name, abort);
				if (got != 3) begin
					$display("Malformed test header in the test data: %s", line);
					errorCount++;
				end
				testNames[numTests] = name;
				abortAt[numTests] = abort;
				numTests++;
				rowIdx = 0;
				wordIdx = 0;
			end else if (numTests > 0 && rowIdx < PAD_H) begin
				got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", px[0], px[1], px[2],
					px[3], px[4], px[5], px[6], px[7], px[8], px[9]);
				if (got != PAD_W) begin
					$display("Malformed pixel row in the test data: %s", line);
					errorCount++;
				end
				for (int i = 0; i < PAD_W; i++) begin
					frames[numTests-1][rowIdx*PAD_W+i] = pixel_t'(px[i]);
				end
				rowIdx++;
			end else if (numTests > 0 && wordIdx < WORDS) begin
				got = $sscanf(line, "%h", word);
				if (got != 1) begin
					$display("Malformed expected word in the test data: %s", line);
					errorCount++;
				end
				expected[numTests-1][wordIdx] = outWord_t'(word);
				wordIdx++;
			end else begin
				$display("Unexpected line in the test data: %s", line);
				errorCount++;
			end
		end
		$fclose(fd);
	endtask

	// Memory is reloaded only while the model sees reset
	task automatic restartWith(input int idx);
		@(posedge clk);
		#1;
		reset = 1'b1;
		@(posedge clk);
		loadFrame(idx);
		checkFrame = idx;
		repeat (RESET_CYCLES - 1) @(posedge clk);
		#1;
		reset = 1'b0;
	endtask

	always @(posedge clk) begin
		cycleCount++;
		resetPrev = reset;
	end

	// One outstanding request, random latency of 1 to 4 cycles
	always @(posedge clk) begin
		resetAtEdge = reset;
		#1;
		i_valid = 1'b0;
		if (resetAtEdge) begin
			pending = 1'b0;
			reqCount = 0;
		end else begin
			if (pending) begin
				countdown--;
				if (countdown == 0) begin
					i_valid = 1'b1;
					i_data = fetchRow(reqAddress);
					pending = 1'b0;
				end
			end
			if (o_req) begin
				if (pending) begin
					$display("Request at %0t while the previous one is outstanding", $time);
					errorCount++;
				end
				checkValue(o_rdAddress, expectedAddress(reqCount),
					$sformatf("address of request %0d", reqCount));
				reqCount++;
				pending = 1'b1;
				reqAddress = o_rdAddress;
				lcgState = nextRandom(lcgState);
				countdown = 1 + int'(lcgState[17:16]);
			end
		end
	end

	always @(negedge clk) begin
		int fired;
		if (resetPrev) begin
			if (o_req || o_valid || o_done) begin
				$display("Outputs active during reset at %0t", $time);
				errorCount++;
			end
			rowsSeen = 0;
			wordsSeen = 0;
			doneSeen = 1'b0;
			fireCycles.delete();
		end else begin
			// Rows from the third of each stripe onward complete a window
			if (i_valid) begin
				if (rowsSeen % PAD_H >= FIRST_FIRE_ROW)
					fireCycles.push_back(cycleCount);
				rowsSeen++;
			end
			if (o_req && doneSeen) begin
				$display("Memory request after done at %0t", $time);
				errorCount++;
			end
			if (o_valid && (wordsSeen >= WORDS || fireCycles.size() == 0)) begin
				$display("Output word at %0t with no window behind it", $time);
				errorCount++;
			end else if (o_valid) begin
				fired = fireCycles.pop_front();
				if (checkFrame >= 0)
					checkValue(o_data, expected[checkFrame][wordsSeen],
						$sformatf("word %0d of frame %0d", wordsSeen, checkFrame));
				checkValue(cycleCount - fired, FIRE_LATENCY, "cycles from row to word");
				checkValue(32'(o_done), 32'(wordsSeen == WORDS - 1), "done flag");
				doneSeen = doneSeen | o_done;
				wordsSeen++;
			end else if (o_done) begin
				$display("Done raised without a valid word at %0t", $time);
				errorCount++;
			end
		end
	end

	initial begin
		wait (numTests > 0);
		repeat (numTests * CYCLES_PER_TEST) @(posedge clk);
		$display("Timeout: the engine did not finish within %0d cycles",
			numTests * CYCLES_PER_TEST);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		int errorsBefore;
		int testsPassed;
		int testsFailed;
		testsPassed = 0;
		testsFailed = 0;
		loadFrame(-1);
		loadTests();
		if (numTests == 0) begin
			$display("No tests could be read from convEngine_testdata.txt");
			$display("Test FAILED");
		end else begin
			for (int t = 0; t < numTests; t++) begin
				errorsBefore = errorCount;
				if (abortAt[t] > 0) begin
					// Start on the frame still in memory and cut it short
					restartWith(t - 1);
					while (wordsSeen < abortAt[t])
						@(posedge clk);
				end
				restartWith(t);
				while (!doneSeen)
					@(posedge clk);
				repeat (QUIET_CYCLES) @(posedge clk);
				checkValue(wordsSeen, WORDS, $sformatf("word count of %s", testNames[t]));
				if (errorCount == errorsBefore) begin
					testsPassed++;
					$display("%s: passed", testNames[t]);
				end else begin
					testsFailed++;
					$display("%s: failed with %0d errors", testNames[t],
						errorCount - errorsBefore);
				end
			end
			$display("%0d tests passed, %0d tests failed, %0d errors",
				testsPassed, testsFailed, errorCount);
			if (testsFailed == 0 && errorCount == 0)
				$display("Test OK");
			else
				$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== convEngine_testdata.txt ====
# Each test: "test <name> <words before a mid-frame reset, 0 for none>", then 6 padded
# rows of 10 hex pixels, then 8 expected output words in hex with lane 0 in the low byte
test ramp 0
00 00 00 00 00 00 00 00 00 00
00 01 02 03 04 05 06 07 08 00
00 09 0a 0b 0c 0d 0e 0f 10 00
00 11 12 13 14 15 16 17 18 00
00 19 1a 1b 1c 1d 1e 1f 20 00
00 00 00 00 00 00 00 00 00 00
00000000
0c0b0a21
14131241
888480a4
22040000
430f0e0d
63171615
d294908c
test clamp 0
00 00 00 00 00 00 00 00 00 00
00 10 10 10 10 f0 f0 f0 f0 00
00 10 ff 10 10 f0 f0 f0 f0 00
00 10 10 10 10 f0 f0 00 f0 00
00 10 10 10 10 f0 f0 f0 f0 00
00 00 00 00 00 00 00 00 00 00
00000000
0000ff00
00000000
00404060
ffffffff
ffffffff
ff00ffff
ffffffff
test reuse 3
00 00 00 00 00 00 00 00 00 00
00 20 20 20 20 20 20 20 20 00
00 20 20 20 20 20 20 20 20 00
00 20 20 20 20 20 20 20 20 00
00 20 20 20 20 20 20 20 20 00
00 00 00 00 00 00 00 00 00 00
808080c0
20202080
20202080
808080c0
c0808080
80202020
80202020
c0808080

// ==== all.f ====
kernelPkg.sv
frameBusPkg.sv
kernelLane.sv
filterArray.sv
stripeSequencer.sv
convEngine.sv
tb_convEngine.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_convEngine -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^Test OK$"; then
	exit 0
fi
exit 1
